// ==== verilog/cache_geom_pkg.sv ====
// cache geometry and address layout, referenced by scoped name from the RTL and testbench
package cache_geom_pkg;

    localparam int LINE_BYTES     = 16;
    localparam int WORDS_PER_LINE = LINE_BYTES / 4;
    localparam int SETS           = 64;

    localparam int OFFSET_W = $clog2(LINE_BYTES);
    localparam int INDEX_W  = $clog2(SETS);
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;
    localparam int BANK_W   = $clog2(WORDS_PER_LINE);  // word select inside a line

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [BANK_W-1:0]  bank_t;

    // tag in the msbs, then set index and byte offset
    typedef struct packed {
        tag_t                tag;
        index_t              index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } cache_addr_t;

endpackage

// ==== verilog/cache_bus_pkg.sv ====
// data types shared by the cpu port and the memory port of the cache
package cache_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;  // one bit per byte lane

    // word 0 sits in bits 31:0
    typedef logic [127:0] line_t;

endpackage

// ==== verilog/cache_fsm.sv ====
// main cache controller, sequences lookup, write-back and refill and drives both handshakes
`timescale 1ns/1ps

module cache_fsm (
    input  logic clk,
    input  logic reset,
    input  logic valid,
    input  logic req_write,
    input  logic hit,
    input  logic victim_dirty,
    input  logic rd_rdy,
    input  logic wr_rdy,
    input  logic ret_valid,
    input  logic ret_last,
    input  logic refill_word_hit,
    output logic addr_ok,
    output logic data_ok,
    output logic accept,
    output logic lookup,
    output logic hit_write,
    output logic miss,
    output logic refill_write,
    output logic rd_req,
    output logic wr_req,
    output logic counter_clear
);

    typedef enum logic [2:0] {IDLE, LOOKUP, MISS, DIRTY_MISS, REFILL} state_t;

    state_t state, state_next;

    always_ff @(posedge clk) begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (valid) state_next = LOOKUP;
            LOOKUP: begin
                if (hit)
                    state_next = valid ? LOOKUP : IDLE;  // back-to-back hits stay here
                else
                    state_next = victim_dirty ? DIRTY_MISS : MISS;
            end
            MISS:       if (rd_rdy) state_next = REFILL;
            DIRTY_MISS: if (wr_rdy) state_next = MISS;  // fetch follows the write-back
            REFILL:     if (ret_valid && ret_last) state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    assign lookup        = (state == LOOKUP);
    assign addr_ok       = (state == IDLE) || (lookup && hit);
    assign accept        = valid && addr_ok;
    assign miss          = lookup && !hit;
    assign hit_write     = lookup && hit && req_write;
    assign refill_write  = (state == REFILL) && ret_valid;
    assign rd_req        = (state == MISS);
    assign wr_req        = (state == DIRTY_MISS);
    assign counter_clear = lookup;

    // writes never wait for the refill
    assign data_ok = (lookup && (hit || req_write))
                  || (refill_write && !req_write && refill_word_hit);

endmodule

// ==== verilog/refill_counter.sv ====
// word pointer for an incoming refill burst, used as the data array write address
`timescale 1ns/1ps

module refill_counter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  advance,
    output cache_geom_pkg::bank_t ptr
);

    always_ff @(posedge clk) begin
        if (reset || clear)
            ptr <= '0;
        else if (advance)
            ptr <= ptr + 1'b1;  // wraps after the last word
    end

endmodule

// ==== verilog/request_buffer.sv ====
// holds the accepted cpu request and builds the line addresses for the memory side
`timescale 1ns/1ps

module request_buffer (
    input  logic                   clk,
    input  logic                   accept,
    input  cache_bus_pkg::word_t   addr,
    input  logic                   write,
    input  cache_bus_pkg::strb_t   wstrb,
    input  cache_bus_pkg::word_t   wdata,
    input  cache_geom_pkg::bank_t  ptr,
    input  cache_geom_pkg::tag_t   victim_tag,
    output cache_geom_pkg::tag_t   req_tag,
    output cache_geom_pkg::index_t req_index,
    output cache_geom_pkg::bank_t  req_bank,
    output logic                   req_write,
    output cache_bus_pkg::strb_t   req_wstrb,
    output cache_bus_pkg::word_t   req_wdata,
    output logic                   refill_word_hit,
    output cache_bus_pkg::word_t   rd_addr,
    output cache_bus_pkg::word_t   wr_addr
);

    cache_geom_pkg::cache_addr_t in_addr;
    cache_geom_pkg::cache_addr_t rd_line;
    cache_geom_pkg::cache_addr_t wr_line;

    assign in_addr.raw = addr;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag   <= in_addr.fields.tag;
            req_index <= in_addr.fields.index;
            req_bank  <= in_addr.fields.offset[cache_geom_pkg::OFFSET_W-1:2];
            req_write <= write;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    // both memory addresses are line aligned
    always_comb begin
        rd_line.fields.tag    = req_tag;
        rd_line.fields.index  = req_index;
        rd_line.fields.offset = '0;
        wr_line.fields.tag    = victim_tag;  // the old line's own address
        wr_line.fields.index  = req_index;
        wr_line.fields.offset = '0;
    end

    assign rd_addr = rd_line.raw;
    assign wr_addr = wr_line.raw;

    assign refill_word_hit = (ptr == req_bank);  // requested word arriving now

endmodule

// ==== verilog/cache_tag_array.sv ====
// per-way tag, valid and dirty storage with tag compare and victim status
`timescale 1ns/1ps

module cache_tag_array #(
    parameter int NUM_WAY = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_geom_pkg::index_t index,
    input  cache_geom_pkg::tag_t   tag,
    input  logic                   hit_write,
    input  logic                   refill_write,
    input  logic                   ret_last,
    input  logic                   req_write,
    input  logic [NUM_WAY-1:0]     victim_way,
    output logic                   hit,
    output logic [NUM_WAY-1:0]     hit_way,
    output logic [NUM_WAY-1:0]     valid_ways,
    output cache_geom_pkg::tag_t   victim_tag,
    output logic                   victim_dirty
);

    cache_geom_pkg::tag_t tags [NUM_WAY][cache_geom_pkg::SETS];
    logic [NUM_WAY-1:0] valid_bits [cache_geom_pkg::SETS];
    logic [NUM_WAY-1:0] dirty_bits [cache_geom_pkg::SETS];

    logic line_done;

    assign line_done = refill_write && ret_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < cache_geom_pkg::SETS; s++) begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
            end
        end else if (line_done) begin
            valid_bits[index] <= valid_bits[index] | victim_way;
            // write-allocate leaves the new line dirty
            if (req_write)
                dirty_bits[index] <= dirty_bits[index] | victim_way;
            else
                dirty_bits[index] <= dirty_bits[index] & ~victim_way;
        end else if (hit_write) begin
            dirty_bits[index] <= dirty_bits[index] | hit_way;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAY; w++)
            if (line_done && victim_way[w]) tags[w][index] <= tag;
    end

    assign valid_ways = valid_bits[index];

    always_comb begin
        hit_way    = '0;
        victim_tag = '0;
        for (int w = 0; w < NUM_WAY; w++) begin
            hit_way[w] = valid_ways[w] && (tags[w][index] == tag);
            if (victim_way[w]) victim_tag = tags[w][index];
        end
    end

    assign hit          = |hit_way;
    assign victim_dirty = |(victim_way & valid_ways & dirty_bits[index]);

endmodule

// ==== verilog/cache_data_array.sv ====
// line storage per way, serves hit reads, strobed hit writes and refill words
`timescale 1ns/1ps

module cache_data_array #(
    parameter int NUM_WAY = 2
) (
    input  logic                   clk,
    input  cache_geom_pkg::index_t index,
    input  cache_geom_pkg::bank_t  bank,
    input  logic                   lookup,
    input  logic [NUM_WAY-1:0]     hit_way,
    input  logic                   hit_write,
    input  cache_bus_pkg::strb_t   wstrb,
    input  cache_bus_pkg::word_t   wdata,
    input  logic                   refill_write,
    input  logic [NUM_WAY-1:0]     victim_way,
    input  cache_geom_pkg::bank_t  ptr,
    input  cache_bus_pkg::word_t   ret_data,
    input  logic                   req_write,
    input  logic                   refill_word_hit,
    output cache_bus_pkg::word_t   rdata,
    output cache_bus_pkg::line_t   victim_line
);

    cache_bus_pkg::word_t mem [NUM_WAY][cache_geom_pkg::SETS][cache_geom_pkg::WORDS_PER_LINE];

    cache_bus_pkg::word_t hit_word;
    cache_bus_pkg::word_t refill_word;

    // new write bytes go over the returned word on a write miss
    always_comb begin
        refill_word = ret_data;
        if (req_write && refill_word_hit) begin
            for (int b = 0; b < 4; b++)
                if (wstrb[b]) refill_word[b*8 +: 8] = wdata[b*8 +: 8];
        end
    end

    always_comb begin
        hit_word    = '0;
        victim_line = '0;
        for (int w = 0; w < NUM_WAY; w++) begin
            if (hit_way[w]) hit_word = mem[w][index][bank];
            if (victim_way[w]) begin
                for (int k = 0; k < cache_geom_pkg::WORDS_PER_LINE; k++)
                    victim_line[k*32 +: 32] = mem[w][index][k];
            end
        end
    end

    assign rdata = lookup ? hit_word : refill_word;

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAY; w++) begin
            if (hit_write && hit_way[w]) begin
                for (int b = 0; b < 4; b++)
                    if (wstrb[b]) mem[w][index][bank][b*8 +: 8] <= wdata[b*8 +: 8];
            end
            if (refill_write && victim_way[w])
                mem[w][index][ptr] <= refill_word;
        end
    end

endmodule

// ==== verilog/victim_select.sv ====
// picks the way to replace on a miss, invalid ways first, else lfsr based
`timescale 1ns/1ps

module victim_select #(
    parameter int NUM_WAY = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               miss,
    input  logic [NUM_WAY-1:0] valid_ways,
    output logic [NUM_WAY-1:0] victim_way
);

    logic [7:0]         lfsr;
    logic [NUM_WAY-1:0] choice;
    logic [NUM_WAY-1:0] victim_q;

    always_comb begin
        choice = NUM_WAY'(1) << (lfsr % NUM_WAY);
        for (int w = NUM_WAY - 1; w >= 0; w--)
            if (!valid_ways[w]) choice = NUM_WAY'(1) << w;  // lowest free way wins
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr     <= 8'hb5;
            victim_q <= NUM_WAY'(1);
        end else if (miss) begin
            lfsr     <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            victim_q <= choice;
        end
    end

    // live choice in the miss cycle and the held copy after it
    assign victim_way = miss ? choice : victim_q;

endmodule

// ==== verilog/cache_top.sv ====
// top level of the set-associative write-back cache, instantiate this from the testbench
`timescale 1ns/1ps

module cache_top #(
    parameter int NUM_WAY = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  logic                 write,
    input  cache_bus_pkg::word_t addr,
    input  cache_bus_pkg::strb_t wstrb,
    input  cache_bus_pkg::word_t wdata,
    output logic                 addr_ok,
    output logic                 data_ok,
    output cache_bus_pkg::word_t rdata,
    output logic                 rd_req,
    output cache_bus_pkg::word_t rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  cache_bus_pkg::word_t ret_data,
    output logic                 wr_req,
    output cache_bus_pkg::word_t wr_addr,
    output cache_bus_pkg::line_t wr_data,
    input  logic                 wr_rdy
);

    logic accept, lookup, hit, miss, hit_write, refill_write, counter_clear;
    logic victim_dirty, refill_word_hit, req_write;
    logic [NUM_WAY-1:0] hit_way, valid_ways, victim_way;
    cache_geom_pkg::tag_t   req_tag, victim_tag;
    cache_geom_pkg::index_t req_index;
    cache_geom_pkg::bank_t  req_bank, ptr;
    cache_bus_pkg::strb_t   req_wstrb;
    cache_bus_pkg::word_t   req_wdata;

    cache_fsm cache_fsm_inst (
        .clk(clk), .reset(reset), .valid(valid), .req_write(req_write),
        .hit(hit), .victim_dirty(victim_dirty), .rd_rdy(rd_rdy), .wr_rdy(wr_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .refill_word_hit(refill_word_hit),
        .addr_ok(addr_ok), .data_ok(data_ok), .accept(accept), .lookup(lookup),
        .hit_write(hit_write), .miss(miss), .refill_write(refill_write),
        .rd_req(rd_req), .wr_req(wr_req), .counter_clear(counter_clear)
    );

    refill_counter refill_counter_inst (
        .clk(clk), .reset(reset), .clear(counter_clear), .advance(refill_write), .ptr(ptr)
    );

    request_buffer request_buffer_inst (
        .clk(clk), .accept(accept), .addr(addr), .write(write), .wstrb(wstrb),
        .wdata(wdata), .ptr(ptr), .victim_tag(victim_tag), .req_tag(req_tag),
        .req_index(req_index), .req_bank(req_bank), .req_write(req_write),
        .req_wstrb(req_wstrb), .req_wdata(req_wdata), .refill_word_hit(refill_word_hit),
        .rd_addr(rd_addr), .wr_addr(wr_addr)
    );

    cache_tag_array #(.NUM_WAY(NUM_WAY)) cache_tag_array_inst (
        .clk(clk), .reset(reset), .index(req_index), .tag(req_tag),
        .hit_write(hit_write), .refill_write(refill_write), .ret_last(ret_last),
        .req_write(req_write), .victim_way(victim_way), .hit(hit), .hit_way(hit_way),
        .valid_ways(valid_ways), .victim_tag(victim_tag), .victim_dirty(victim_dirty)
    );

    cache_data_array #(.NUM_WAY(NUM_WAY)) cache_data_array_inst (
        .clk(clk), .index(req_index), .bank(req_bank), .lookup(lookup),
        .hit_way(hit_way), .hit_write(hit_write), .wstrb(req_wstrb), .wdata(req_wdata),
        .refill_write(refill_write), .victim_way(victim_way), .ptr(ptr),
        .ret_data(ret_data), .req_write(req_write), .refill_word_hit(refill_word_hit),
        .rdata(rdata), .victim_line(wr_data)
    );

    victim_select #(.NUM_WAY(NUM_WAY)) victim_select_inst (
        .clk(clk), .reset(reset), .miss(miss), .valid_ways(valid_ways),
        .victim_way(victim_way)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
// clock and reset source for the cache testbench, 10 ns period with reset held for 10 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;  // released just after the tenth edge
    end

endmodule

// ==== tb/mem_model.sv ====
// behavioral main memory for the cache testbench, answers read bursts and line write-backs
`timescale 1ns/1ps

module mem_model #(
    parameter int          MEM_WORDS = 4096,
    parameter logic [31:0] SEED      = 32'hc4a4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rd_req,
    input  cache_bus_pkg::word_t rd_addr,
    output logic                 rd_rdy,
    output logic                 ret_valid,
    output logic                 ret_last,
    output cache_bus_pkg::word_t ret_data,
    input  logic                 wr_req,
    input  cache_bus_pkg::word_t wr_addr,
    input  cache_bus_pkg::line_t wr_data,
    output logic                 wr_rdy
);

    cache_bus_pkg::word_t mem [MEM_WORDS];

    // upper address bits alias onto the array
    function automatic int word_index(cache_bus_pkg::word_t a);
        return int'((a >> 2) % MEM_WORDS);
    endfunction

    task automatic serve_read();
        int base;
        base = word_index(rd_addr);
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        #1 rd_rdy = 1'b1;
        @(posedge clk);
        #1 rd_rdy = 1'b0;
        for (int k = 0; k < 4; k++) begin
            repeat ($urandom % 3) begin  // gap between beats
                @(posedge clk);
                #1;
            end
            ret_valid = 1'b1;
            ret_last  = (k == 3);
            ret_data  = mem[base + k];
            @(posedge clk);
            #1;
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    endtask

    task automatic serve_write();
        int base;
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        #1 wr_rdy = 1'b1;
        base = word_index(wr_addr);
        for (int k = 0; k < 4; k++)
            mem[base + k] = wr_data[k*32 +: 32];
        @(posedge clk);
        #1 wr_rdy = 1'b0;
    endtask

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = $urandom;
        forever begin
            @(negedge clk);
            if (!reset && rd_req)
                serve_read();
            else if (!reset && wr_req)
                serve_write();
        end
    end

endmodule

// ==== tb/cache_tb.sv ====
// self-checking testbench for the cache, runs an operation table against a byte reference memory
`timescale 1ns/1ps

module cache_tb #(
    parameter logic [31:0] SEED = 32'hc4a4
);

    localparam int MEM_WORDS      = 4096;
    localparam int TIMEOUT_CYCLES = 200;
    localparam logic [1:0] KIND_ANY  = 2'd0;  // hit or miss not predictable
    localparam logic [1:0] KIND_HIT  = 2'd1;
    localparam logic [1:0] KIND_MISS = 2'd2;

    typedef struct packed {
        logic                 write;
        cache_bus_pkg::word_t addr;
        cache_bus_pkg::strb_t strb;
        cache_bus_pkg::word_t data;
        logic [1:0]           kind;
        logic                 b2b;  // issued in the lookup cycle of the previous op
    } op_t;

    logic clk, reset;
    logic valid, write, addr_ok, data_ok;
    cache_bus_pkg::word_t addr, wdata, rdata;
    cache_bus_pkg::strb_t wstrb;
    logic rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    cache_bus_pkg::word_t rd_addr, ret_data, wr_addr;
    cache_bus_pkg::line_t wr_data;

    op_t        ops [$];
    logic [7:0] ref_mem [MEM_WORDS*4];
    logic       written_set [cache_geom_pkg::SETS];
    int         cycle = 0;
    int         rd_bursts = 0;
    int         accept_cycle, next_accept_cycle, rd_bursts_at_accept;
    bit         already_accepted;
    cache_bus_pkg::word_t last_rd_addr;

    tb_clock_gen tb_clock_gen_inst (.clk(clk), .reset(reset));

    mem_model #(.MEM_WORDS(MEM_WORDS), .SEED(SEED)) mem_model_inst (
        .clk(clk), .reset(reset), .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    cache_top #(.NUM_WAY(2)) cache_top_inst (
        .clk(clk), .reset(reset), .valid(valid), .write(write), .addr(addr),
        .wstrb(wstrb), .wdata(wdata), .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy), .ret_valid(ret_valid),
        .ret_last(ret_last), .ret_data(ret_data), .wr_req(wr_req), .wr_addr(wr_addr),
        .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    task automatic end_with_failure(string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(string name, cache_bus_pkg::word_t exp,
                                   cache_bus_pkg::word_t act);
        end_with_failure($sformatf("Fail at %0t ns: %s expected %h, got %h",
                                   $time, name, exp, act));
    endtask

    task automatic report_error(string msg);
        end_with_failure($sformatf("Error at %0t ns: %s", $time, msg));
    endtask

    function automatic int byte_base(cache_bus_pkg::word_t a);
        return int'(a % (MEM_WORDS * 4)) & ~3;
    endfunction

    function automatic cache_bus_pkg::word_t ref_word(cache_bus_pkg::word_t a);
        int b;
        b = byte_base(a);
        return {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
    endfunction

    function automatic int set_of(cache_bus_pkg::word_t a);
        return int'(a[cache_geom_pkg::OFFSET_W +: cache_geom_pkg::INDEX_W]);
    endfunction

    task automatic add_op(logic wr, cache_bus_pkg::word_t a, cache_bus_pkg::strb_t s,
                          cache_bus_pkg::word_t d, logic [1:0] kind, logic b2b);
        op_t op;
        op.write = wr;
        op.addr  = a;
        op.strb  = s;
        op.data  = d;
        op.kind  = kind;
        op.b2b   = b2b;
        ops.push_back(op);
    endtask

    task automatic load_table();
        //     wr    addr           strb     data           expect     b2b
        add_op(1'b0, 32'h0000_0100, 4'b0000, 32'h0000_0000, KIND_MISS, 1'b0);
        add_op(1'b0, 32'h0000_0104, 4'b0000, 32'h0000_0000, KIND_HIT,  1'b0);
        add_op(1'b0, 32'h0000_0108, 4'b0000, 32'h0000_0000, KIND_HIT,  1'b1);
        add_op(1'b0, 32'h0000_010c, 4'b0000, 32'h0000_0000, KIND_HIT,  1'b1);
        add_op(1'b1, 32'h0000_0104, 4'b0110, 32'ha5a5_5a5a, KIND_HIT,  1'b0);
        add_op(1'b0, 32'h0000_0104, 4'b0000, 32'h0000_0000, KIND_HIT,  1'b1);
        add_op(1'b1, 32'h0000_0228, 4'b1001, 32'h1234_5678, KIND_MISS, 1'b0);
        add_op(1'b0, 32'h0000_0228, 4'b0000, 32'h0000_0000, KIND_HIT,  1'b0);
        add_op(1'b0, 32'h0000_0220, 4'b0000, 32'h0000_0000, KIND_HIT,  1'b0);
        // five tags on set 4 with two of them dirty
        add_op(1'b1, 32'h0000_0040, 4'b1111, 32'hdead_beef, KIND_MISS, 1'b0);
        add_op(1'b1, 32'h0000_044c, 4'b0011, 32'h0000_cafe, KIND_MISS, 1'b0);
        add_op(1'b0, 32'h0000_0844, 4'b0000, 32'h0000_0000, KIND_MISS, 1'b0);
        add_op(1'b0, 32'h0000_0c40, 4'b0000, 32'h0000_0000, KIND_MISS, 1'b0);
        add_op(1'b0, 32'h0000_1048, 4'b0000, 32'h0000_0000, KIND_MISS, 1'b0);
        add_op(1'b0, 32'h0000_0040, 4'b0000, 32'h0000_0000, KIND_ANY,  1'b0);
        add_op(1'b0, 32'h0000_044c, 4'b0000, 32'h0000_0000, KIND_ANY,  1'b0);
        // set 0x30 is only read
        add_op(1'b0, 32'h0000_0300, 4'b0000, 32'h0000_0000, KIND_MISS, 1'b0);
        add_op(1'b0, 32'h0000_0704, 4'b0000, 32'h0000_0000, KIND_MISS, 1'b0);
        add_op(1'b0, 32'h0000_0b08, 4'b0000, 32'h0000_0000, KIND_MISS, 1'b0);
        add_op(1'b0, 32'h0000_0300, 4'b0000, 32'h0000_0000, KIND_ANY,  1'b0);
    endtask

    task automatic drive_op(op_t op);
        valid = 1'b1;
        write = op.write;
        addr  = op.addr;
        wstrb = op.strb;
        wdata = op.data;
    endtask

    task automatic wait_accept();
        int  n;
        bit  done;
        n    = 0;
        done = 0;
        while (!done) begin
            @(negedge clk);
            if (addr_ok) begin
                accept_cycle        = cycle;
                rd_bursts_at_accept = rd_bursts;
                done                = 1;
            end else begin
                n++;
                if (n > TIMEOUT_CYCLES) report_error("request never accepted, addr_ok low");
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_response(op_t op);
        cache_bus_pkg::word_t exp;
        cache_bus_pkg::word_t line;
        line = op.addr & ~(cache_bus_pkg::word_t'(cache_geom_pkg::LINE_BYTES - 1));
        if (op.write || op.kind == KIND_HIT)
            assert (cycle == accept_cycle + 1)
                else report_mismatch("data_ok cycle", accept_cycle + 1, cycle);
        if (op.write) begin
            for (int b = 0; b < 4; b++)
                if (op.strb[b]) ref_mem[byte_base(op.addr) + b] = op.data[b*8 +: 8];
            written_set[set_of(op.addr)] = 1'b1;
        end else begin
            exp = ref_word(op.addr);
            assert (rdata === exp) else report_mismatch("rdata", exp, rdata);
            if (op.kind == KIND_MISS) begin
                assert (rd_bursts > rd_bursts_at_accept)
                    else report_error("read miss finished without a read burst");
                assert (last_rd_addr == line) else report_mismatch("rd_addr", line, last_rd_addr);
            end
        end
    endtask

    task automatic wait_data_ok(op_t op, bit next_b2b);
        int n;
        bit got;
        n   = 0;
        got = 0;
        while (!got) begin
            @(negedge clk);
            if (next_b2b && valid && addr_ok && !already_accepted) begin
                already_accepted  = 1;
                next_accept_cycle = cycle;
            end
            if (data_ok) begin
                check_response(op);
                got = 1;
            end else begin
                n++;
                if (n > TIMEOUT_CYCLES) report_error("no data_ok for an accepted request");
            end
        end
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) cycle <= cycle + 1;

    // memory side monitor
    always @(negedge clk) begin
        if (!reset && rd_req && rd_rdy) begin
            assert (rd_addr[cache_geom_pkg::OFFSET_W-1:0] == '0)
                else report_error("rd_addr is not line aligned");
            last_rd_addr = rd_addr;
            rd_bursts++;
        end
        if (!reset && wr_req) begin
            assert (written_set[set_of(wr_addr)])
                else report_error("write-back requested for a set that was only read");
            if (wr_rdy) begin
                assert (wr_addr[cache_geom_pkg::OFFSET_W-1:0] == '0)
                    else report_error("wr_addr is not line aligned");
                for (int k = 0; k < cache_geom_pkg::WORDS_PER_LINE; k++)
                    assert (wr_data[k*32 +: 32] == ref_word(wr_addr + 32'(4 * k)))
                        else report_mismatch($sformatf("wr_data word %0d", k),
                                             ref_word(wr_addr + 32'(4 * k)), wr_data[k*32 +: 32]);
            end
        end
    end

    initial begin
        op_t op;
        bit  next_b2b;
        int  n;
        valid = 1'b0;
        write = 1'b0;
        addr  = '0;
        wstrb = '0;
        wdata = '0;
        already_accepted = 0;
        for (int s = 0; s < cache_geom_pkg::SETS; s++)
            written_set[s] = 1'b0;
        load_table();

        // reset is surely high by the first edge
        n = 0;
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT_CYCLES) report_error("reset was never released");
        end
        @(posedge clk);
        #1;

        // reference starts from the memory model's random content
        for (int i = 0; i < MEM_WORDS; i++)
            for (int b = 0; b < 4; b++)
                ref_mem[i*4 + b] = mem_model_inst.mem[i][b*8 +: 8];

        for (int i = 0; i < ops.size(); i++) begin
            op       = ops[i];
            next_b2b = (i + 1 < ops.size()) && ops[i + 1].b2b;
            if (!already_accepted) begin
                drive_op(op);
                wait_accept();
            end else begin
                accept_cycle        = next_accept_cycle;
                rd_bursts_at_accept = rd_bursts;
            end
            already_accepted = 0;
            if (next_b2b)
                drive_op(ops[i + 1]);
            else
                valid = 1'b0;
            wait_data_ok(op, next_b2b);
            if (next_b2b && op.kind == KIND_HIT)
                assert (already_accepted && next_accept_cycle == accept_cycle + 1)
                    else report_error("back-to-back request not accepted in the next cycle");
        end

        valid = 1'b0;
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
verilog/cache_geom_pkg.sv
verilog/cache_bus_pkg.sv
verilog/cache_fsm.sv
verilog/refill_counter.sv
verilog/request_buffer.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/victim_select.sv
verilog/cache_top.sv
tb/tb_clock_gen.sv
tb/mem_model.sv
tb/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
LOG       ?= sim.log
SEED      ?= 50340
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP LOG SEED"

test:
	$(VERILATOR) --binary -Wno-fatal -f project.f --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
